/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fetch_top
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* build.f */
+incdir+sim
logic/fetch_pkg.sv
logic/static_predictor.sv
logic/fetch_hazard_unit.sv
logic/fetch_stage.sv
logic/fetch_config_regs.sv
logic/fetch_top.sv
sim/tb_fetch_top.sv

/* logic/fetch_config_regs.sv */
`default_nettype none

module fetch_config_regs (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 cfg_req,
  input  logic                 cfg_addr,
  input  fetch_pkg::word_t     cfg_wdata,
  output logic                 cfg_ack,
  output fetch_pkg::pred_cfg_t cfg
);
  import fetch_pkg::*;

  logic wr_en;                                      // first cycle of a request.

  assign wr_en = cfg_req && !cfg_ack;               // one write per handshake.

  //////////////////////////////
  // four-phase slave
  //////////////////////////////

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_ack <= 1'b0;
    end else if (wr_en) begin
      cfg_ack <= 1'b1;                              // ack one clock after req.
    end else if (!cfg_req && cfg_ack) begin
      cfg_ack <= 1'b0;                              // release after req drops.
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg.predict_en  <= 1'b0;                      // prediction off at start.
      cfg.trap_vector <= TRAP_VECTOR_RESET;
    end else if (wr_en) begin
      case (cfg_addr)
        CFG_PREDICT: begin
          cfg.predict_en <= cfg_wdata[0];
        end
        CFG_TRAP_VEC: begin
          cfg.trap_vector <= {cfg_wdata[31:2], 2'b00}; // keep it word aligned.
        end
      endcase
    end
  end

  // master must still be requesting on the clock that ack rises.
  a_ack_follows_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(cfg_ack) |-> $past(cfg_req));

endmodule

`default_nettype wire

/* logic/fetch_hazard_unit.sv */
`default_nettype none

module fetch_hazard_unit (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                busy,
  input  logic                ex_stall,
  input  logic                redirect_valid,
  input  logic                mal_insn,
  input  logic                predict_taken,
  output logic                pc_en,
  output logic                iren,
  output logic                if_ex_stall,
  output logic                if_ex_flush,
  output fetch_pkg::npc_sel_t npc_sel
);
  import fetch_pkg::*;

  logic word_valid;                                 // bus returned the word this cycle.

  assign word_valid = iren && !busy;

  //////////////////////////////
  // control
  //////////////////////////////

  assign iren        = !mal_insn;                   // never fetch unaligned.
  assign if_ex_flush = mal_insn || redirect_valid;  // trap or redirect kills the word.
  assign if_ex_stall = ex_stall;                    // execute holds the register.

  // a flush moves the pc regardless of bus state or stall.
  assign pc_en = if_ex_flush || (word_valid && !ex_stall);

  always_comb begin
    if (mal_insn) begin
      npc_sel = SEL_TRAP;                           // highest priority.
    end else if (redirect_valid) begin
      npc_sel = SEL_REDIRECT;
    end else if (predict_taken && word_valid) begin
      npc_sel = SEL_PREDICT;                        // only on a real word.
    end else begin
      npc_sel = SEL_SEQ;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // advancing while execute holds would drop a word.
  a_no_adv_in_stall: assert property (@(posedge CLK) disable iff (!nRST)
    (pc_en && if_ex_stall) |-> if_ex_flush);

  // the fault from the stage must always steer to the trap vector.
  a_trap_sel: assert property (@(posedge CLK) disable iff (!nRST)
    mal_insn |-> (npc_sel == SEL_TRAP));

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  //////////////////////////////
  // basic types and constants
  //////////////////////////////

  typedef logic [31:0] word_t;                      // machine word.

  localparam word_t RESET_PC          = 32'h200;    // pc out of reset.
  localparam word_t TRAP_VECTOR_RESET = 32'h100;    // trap vector out of reset.
  localparam bit    BUS_LITTLE_ENDIAN = 1'b1;       // swap rdata bytes when set.

  localparam logic [6:0] OPC_JAL    = 7'b1101111;   // jal opcode.
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // conditional branch opcode.

  localparam logic CFG_PREDICT  = 1'b0;             // config addr of predict enable.
  localparam logic CFG_TRAP_VEC = 1'b1;             // config addr of trap vector.

  //////////////////////////////
  // pipeline and bus bundles
  //////////////////////////////

  typedef struct packed {
    logic  token;                                   // valid word in the register.
    word_t pc;                                      // pc of the fetched word.
    word_t pc4;                                     // sequential successor.
    word_t instr;                                   // word in core byte order.
    logic  prediction;                              // fetch predicted taken.
  } fetch_ex_t;                                     // 98 bits.

  typedef struct packed {
    logic  valid;                                   // execute resolved a redirect.
    word_t target;                                  // where to fetch next.
  } ex_redirect_t;

  typedef struct packed {
    logic  mal_insn;                                // misaligned fetch address.
    word_t epc;                                     // pc of the faulting fetch.
    word_t badaddr;                                 // offending bus address.
  } fetch_fault_t;

  typedef struct packed {
    word_t addr;                                    // word address on the bus.
    logic  ren;                                     // read request.
  } imem_req_t;

  typedef enum logic [1:0] {
    SEL_TRAP,                                       // trap vector.
    SEL_REDIRECT,                                   // execute redirect target.
    SEL_PREDICT,                                    // static predictor target.
    SEL_SEQ                                         // pc + 4.
  } npc_sel_t;

  //////////////////////////////
  // instruction views
  //////////////////////////////

  typedef struct packed {
    logic       imm20;                              // sign bit.
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef struct packed {
    logic       imm12;                              // sign bit, set for backward.
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef union packed {
    j_type_t j;                                     // jal decode.
    b_type_t b;                                     // branch decode.
  } instr_u;

  typedef struct packed {
    logic  predict_en;                              // static prediction on.
    word_t trap_vector;                             // word aligned trap target.
  } pred_cfg_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`default_nettype none

module fetch_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  fetch_pkg::npc_sel_t     npc_sel,
  input  logic                    pc_en,
  input  logic                    if_ex_stall,
  input  logic                    if_ex_flush,
  input  logic                    iren,
  input  fetch_pkg::ex_redirect_t redirect,
  input  fetch_pkg::word_t        trap_vector,
  input  logic                    predict_taken,
  input  fetch_pkg::word_t        target_addr,
  input  fetch_pkg::word_t        rdata,
  output fetch_pkg::imem_req_t    imem,
  output fetch_pkg::instr_u       instr,
  output fetch_pkg::word_t        pc,
  output fetch_pkg::fetch_ex_t    fetch_ex,
  output fetch_pkg::fetch_fault_t fault
);
  import fetch_pkg::*;

  word_t pc4;                                       // sequential next pc.
  word_t npc;                                       // selected next pc.
  word_t swapped;                                   // rdata in core byte order.
  logic  mal_addr;                                  // pc not word aligned.

  logic  token_q;                                   // fetch/execute control.
  logic  pred_q;
  word_t pc_q;                                      // fetch/execute payload.
  word_t pc4_q;
  word_t instr_q;

  //////////////////////////////
  // program counter
  //////////////////////////////

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;

  always_comb begin
    unique case (npc_sel)
      SEL_TRAP:     npc = trap_vector;
      SEL_REDIRECT: npc = redirect.target;
      SEL_PREDICT:  npc = target_addr;
      default:      npc = pc4;                      // SEL_SEQ.
    endcase
  end

  //////////////////////////////
  // bus and byte order
  //////////////////////////////

  assign imem.addr = pc;
  assign imem.ren  = iren;

  assign swapped = BUS_LITTLE_ENDIAN ?
                   {rdata[7:0], rdata[15:8], rdata[23:16], rdata[31:24]} : rdata;
  assign instr   = swapped;                         // both views see the same word.

  //////////////////////////////
  // fetch/execute register
  //////////////////////////////

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      token_q <= 1'b0;
      pred_q  <= 1'b0;
    end else if (if_ex_flush) begin
      token_q <= 1'b0;                              // bubble on redirect or trap.
      pred_q  <= 1'b0;
    end else if (!if_ex_stall) begin
      token_q <= pc_en;                             // busy bus gives a bubble.
      pred_q  <= pc_en && predict_taken;
    end
  end

  always_ff @(posedge CLK) begin
    if (!if_ex_stall) begin
      pc_q    <= pc;
      pc4_q   <= pc4;
      instr_q <= swapped;
    end
  end

  assign fetch_ex = '{token: token_q, pc: pc_q, pc4: pc4_q,
                      instr: instr_q, prediction: pred_q};

  //////////////////////////////
  // fault
  //////////////////////////////

  assign mal_addr       = (pc[1:0] != 2'b00);
  assign fault.mal_insn = mal_addr;
  assign fault.epc      = pc;
  assign fault.badaddr  = imem.addr;

  a_aligned_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    imem.ren |-> (imem.addr[1:0] == 2'b00));

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none

module fetch_top (
  input  logic                    CLK,
  input  logic                    nRST,
  output fetch_pkg::imem_req_t    imem,
  input  fetch_pkg::word_t        rdata,
  input  logic                    busy,
  input  fetch_pkg::ex_redirect_t redirect,
  input  logic                    ex_stall,
  input  logic                    cfg_req,
  input  logic                    cfg_addr,
  input  fetch_pkg::word_t        cfg_wdata,
  output logic                    cfg_ack,
  output fetch_pkg::fetch_ex_t    fetch_ex,
  output fetch_pkg::fetch_fault_t fault
);
  import fetch_pkg::*;

  npc_sel_t  npc_sel;                               // next-pc source.
  logic      pc_en, iren, if_ex_stall, if_ex_flush;
  logic      predict_taken;
  word_t     target_addr;                           // predicted target.
  word_t     pc;
  instr_u    instr;                                 // swapped word for decode.
  pred_cfg_t cfg;

  //////////////////////////////
  // datapath
  //////////////////////////////

  fetch_stage i_stage (
    .CLK(CLK), .nRST(nRST), .npc_sel(npc_sel), .pc_en(pc_en),
    .if_ex_stall(if_ex_stall), .if_ex_flush(if_ex_flush), .iren(iren),
    .redirect(redirect), .trap_vector(cfg.trap_vector),
    .predict_taken(predict_taken), .target_addr(target_addr), .rdata(rdata),
    .imem(imem), .instr(instr), .pc(pc), .fetch_ex(fetch_ex), .fault(fault)
  );

  static_predictor i_pred (
    .instr(instr), .pc(pc), .predict_en(cfg.predict_en),
    .predict_taken(predict_taken), .target_addr(target_addr)
  );

  //////////////////////////////
  // control
  //////////////////////////////

  fetch_hazard_unit i_hazard (
    .CLK(CLK), .nRST(nRST), .busy(busy), .ex_stall(ex_stall),
    .redirect_valid(redirect.valid), .mal_insn(fault.mal_insn),
    .predict_taken(predict_taken), .pc_en(pc_en), .iren(iren),
    .if_ex_stall(if_ex_stall), .if_ex_flush(if_ex_flush), .npc_sel(npc_sel)
  );

  fetch_config_regs i_cfg (
    .CLK(CLK), .nRST(nRST), .cfg_req(cfg_req), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack), .cfg(cfg)
  );

endmodule

`default_nettype wire

/* logic/static_predictor.sv */
`default_nettype none

module static_predictor (
  input  fetch_pkg::instr_u instr,
  input  fetch_pkg::word_t  pc,
  input  logic              predict_en,
  output logic              predict_taken,
  output fetch_pkg::word_t  target_addr
);
  import fetch_pkg::*;

  logic  is_jal;                                    // unconditional jump.
  logic  is_back_branch;                            // branch with negative offset.
  word_t j_imm;                                     // sign extended jal offset.
  word_t b_imm;                                     // sign extended branch offset.

  //////////////////////////////
  // decode
  //////////////////////////////

  assign is_jal         = (instr.j.opcode == OPC_JAL);
  assign is_back_branch = (instr.b.opcode == OPC_BRANCH) && instr.b.imm12; // btfn rule.

  assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};   // bit 0 always zero.
  assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};

  //////////////////////////////
  // prediction
  //////////////////////////////

  assign predict_taken = predict_en && (is_jal || is_back_branch); // off means not taken.
  assign target_addr   = pc + (is_jal ? j_imm : b_imm);  // pc relative target.

endmodule

`default_nettype wire

/* sim/tb_fetch_model.svh */
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

//////////////////////////////
// random numbers
//////////////////////////////

// fibonacci lfsr, taps 32 22 2 1, one step per bit.
function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    state = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    r     = {r[30:0], state[0]};                  // newest bit at the bottom.
  end
  return r;
endfunction

//////////////////////////////
// memory content
//////////////////////////////

// word at an address in core order, hashed from every address bit.
function automatic logic [31:0] imem_word(input logic [31:0] a);
  logic [31:0] h;
  logic [20:0] joff;
  logic [12:0] boff;
  h    = (a ^ (a >> 7)) * 32'h9e3779b1;
  h    = h ^ (h >> 15);
  joff = {{14{h[20]}}, h[9:5], 2'b00};            // word multiple, either sign.
  boff = {{6{h[21]}}, h[9:5], 2'b00};
  if (h[3:0] < 4'd10) begin
    return {h[31:20], h[19:15], 3'b000, h[14:10], 7'b0010011}; // addi.
  end else if (h[3:0] < 4'd13) begin
    return {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, 7'b1101111};
  end
  return {boff[12], boff[10:5], h[24:20], h[19:15], 3'b001, boff[4:1], boff[11],
          7'b1100011};                            // bne.
endfunction

// the bus delivers bytes little endian.
function automatic logic [31:0] swap32(input logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

//////////////////////////////
// prediction rule
//////////////////////////////

// taken for jal and backward branches, target from the rv32i immediates.
function automatic logic predict_rule(input logic [31:0] w, input logic [31:0] pc,
                                      input logic en, output logic [31:0] tgt);
  logic [31:0] jimm;
  logic [31:0] bimm;
  jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  if (w[6:0] == 7'b1101111) begin
    tgt = pc + jimm;
    return en;
  end
  tgt = pc + bimm;
  return en && (w[6:0] == 7'b1100011) && w[31];   // negative offset only.
endfunction

`endif

/* sim/tb_fetch_top.sv */
`default_nettype none

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  `include "tb_fetch_model.svh"

  logic         CLK, nRST, busy, ex_stall, cfg_req, cfg_addr, cfg_ack;
  word_t        rdata, cfg_wdata;
  imem_req_t    imem;
  ex_redirect_t redirect;
  fetch_ex_t    fetch_ex;
  fetch_fault_t fault;

  logic [31:0] stim_state, bus_state;               // lfsr states.
  word_t       m_pc, m_tv, m_npc, ptgt;             // model pc and trap vector.
  logic        m_pred_en, mal, wv, flush, ptaken, adv;
  logic [1:0]  busy_left;                           // busy cycles still owed.
  logic        exp_token, exp_pred;                 // expected register.
  word_t       exp_pc, exp_pc4, exp_instr;
  int          checks, errors, t0;
  word_t       tok_pc, tgt;

  fetch_top i_dut (
    .CLK(CLK), .nRST(nRST), .imem(imem), .rdata(rdata), .busy(busy),
    .redirect(redirect), .ex_stall(ex_stall), .cfg_req(cfg_req), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack), .fetch_ex(fetch_ex), .fault(fault)
  );

  always #20 CLK = ~CLK;                            // 40 ns period.

  //////////////////////////////
  // memory and model
  //////////////////////////////

  always @(posedge CLK) begin
    if (nRST) begin
      mal    = (m_pc[1:0] != 2'b00);
      wv     = !mal && !busy;                       // word delivered this cycle.
      flush  = mal || redirect.valid;
      ptaken = predict_rule(imem_word(m_pc), m_pc, m_pred_en, ptgt);
      adv    = flush || (wv && !ex_stall);
      if (flush) begin
        exp_token = 1'b0;                           // bubble.
        exp_pred  = 1'b0;
      end else if (!ex_stall) begin
        exp_token = adv;
        exp_pred  = adv && ptaken;
        exp_pc    = m_pc;
        exp_pc4   = m_pc + 32'd4;
        exp_instr = imem_word(m_pc);
      end
      if (adv) begin
        if (mal) m_npc = m_tv;                      // trap first.
        else if (redirect.valid) m_npc = redirect.target;
        else if (ptaken) m_npc = ptgt;
        else m_npc = m_pc + 32'd4;
        m_pc      = m_npc;
        busy_left = 2'(take_bits(bus_state, 2));    // memory restarts.
      end else if (busy_left != 2'd0) begin
        busy_left = busy_left - 2'd1;
      end
      busy  <= (busy_left != 2'd0);
      rdata <= swap32(imem_word(m_pc));
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  always @(negedge CLK) begin
    if (nRST) begin
      check_word("imem.addr", imem.addr, m_pc);
      check_word("imem.ren", 32'(imem.ren), 32'(m_pc[1:0] == 2'b00));
      check_word("fetch_ex.token", 32'(fetch_ex.token), 32'(exp_token));
      if (exp_token) begin                          // payload only counts on a token.
        check_word("fetch_ex.pc", fetch_ex.pc, exp_pc);
        check_word("fetch_ex.pc4", fetch_ex.pc4, exp_pc4);
        check_word("fetch_ex.instr", fetch_ex.instr, exp_instr);
        check_word("fetch_ex.prediction", 32'(fetch_ex.prediction), 32'(exp_pred));
      end
      check_word("fault.mal_insn", 32'(fault.mal_insn), 32'(m_pc[1:0] != 2'b00));
      if (fault.mal_insn) begin
        check_word("fault.epc", fault.epc, m_pc);
        check_word("fault.badaddr", fault.badaddr, m_pc);
      end
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic next_token(output word_t pc);
    int n;
    n = 0;
    @(negedge CLK);
    while (!fetch_ex.token && n < 100) begin
      @(negedge CLK);
      n++;
    end
    if (!fetch_ex.token) timeout_fail("a fetch token");
    pc = fetch_ex.pc;
  endtask

  task automatic run_tokens(input int count);
    word_t pc;
    for (int i = 0; i < count; i++) next_token(pc);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (cfg_ack !== level && n < 20) begin
      @(negedge CLK);
      n++;
    end
    if (cfg_ack !== level) timeout_fail("cfg_ack");
    checks++;
    if (n != 2) begin
      errors++;
      $display("cfg_ack moved %0d cycles after cfg_req instead of one", n - 1);
    end
  endtask

  task automatic cfg_write(input logic a, input word_t d);
    repeat (take_bits(stim_state, 2)) @(posedge CLK); // random gap.
    @(posedge CLK);
    cfg_req   <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    wait_ack(1'b1);
    if (a == CFG_PREDICT) m_pred_en = d[0];
    else m_tv = {d[31:2], 2'b00};                   // low bits never stored.
    @(posedge CLK);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_redirect(input word_t target);
    @(posedge CLK);
    redirect <= '{valid: 1'b1, target: target};
    @(posedge CLK);
    redirect <= '0;                                 // one cycle pulse.
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s", name, (errors == t0) ? "ok" : "failed");
    t0 = errors;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    CLK       = 0;
    nRST      = 0;
    busy      = 0;
    ex_stall  = 0;
    redirect  = '0;
    cfg_req   = 0;
    cfg_addr  = 0;
    cfg_wdata = '0;
    rdata     = swap32(imem_word(RESET_PC));
    m_pc      = RESET_PC;
    m_tv      = TRAP_VECTOR_RESET;
    m_pred_en = 0;
    busy_left = 0;
    exp_token = 0;
    exp_pred  = 0;
    checks    = 0;
    errors    = 0;
    t0        = 0;
    stim_state = 32'hafa2;
    bus_state  = 32'hafa2;
    void'(take_bits(bus_state, 17));                // decouple the bus stream.
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    next_token(tok_pc);                             // 1. reset and sequential.
    check_word("first token pc", tok_pc, RESET_PC);
    run_tokens(20);
    end_test("reset and sequential fetch");

    cfg_write(CFG_PREDICT, 32'h0);                  // 2. config handshake.
    cfg_write(CFG_TRAP_VEC, {22'h0, 2'b11, 6'(take_bits(stim_state, 6)), 2'b11});
    cfg_write(CFG_PREDICT, 32'h0);
    end_test("configuration handshake");

    cfg_write(CFG_PREDICT, 32'h1);                  // 3. static prediction.
    run_tokens(60);
    end_test("static prediction");

    repeat (6) begin                                // 4. redirect and flush.
      tgt = 32'h400 + {8'(take_bits(stim_state, 8)), 2'b00};
      repeat (take_bits(stim_state, 3)) @(posedge CLK);
      send_redirect(tgt);
      next_token(tok_pc);
      check_word("redirect token pc", tok_pc, tgt);
    end
    end_test("redirect and flush");

    tgt = 32'h600 + {6'(take_bits(stim_state, 6)), 2'b00} + 32'd1
          + take_bits(stim_state, 1);
    send_redirect(tgt);                             // 5. misaligned redirect.
    @(negedge CLK);
    check_word("fault.mal_insn", 32'(fault.mal_insn), 32'd1);
    check_word("fault.epc", fault.epc, tgt);
    check_word("fault.badaddr", fault.badaddr, tgt);
    next_token(tok_pc);
    check_word("trap token pc", tok_pc, m_tv);
    end_test("misaligned redirect fault");

    repeat (80) begin                               // 6. downstream stall.
      @(posedge CLK);
      ex_stall <= 1'(take_bits(stim_state, 1));
    end
    @(posedge CLK);
    ex_stall <= 1'b0;
    run_tokens(5);
    end_test("downstream stall");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
